// File: include/frontend_defs.svh
// fetch addresses are a flat 32 bits wide and branch recovery always takes four cycles
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// ==========================================================================
// fetch address
// ==========================================================================

// width of every fetch address carried through the front end
`define ADDR_W 32

// restart address loaded into the redirect target at reset
// it must stay ADDR_W bits wide
`define RESET_PC 32'h0000_0004

// ==========================================================================
// branch recovery
// ==========================================================================

// number of cycles the recovery window lasts
// this matches the number of recovery states in branch_state_t
`define RECOVERY_STEPS 3'd4

`endif

// File: verilog/branch_pkg.sv
// the branch_state_t encoding order is fixed because the recovery window is a range check
package branch_pkg;

	// recovery states in the order the FSM steps through them
	// each recovery state's value is also its step number in the window
	typedef enum logic [2:0] {
		BS_IDLE,
		BS_CHKPT_RESTORE,
		BS_CAPTURE_MISSIP,
		BS_DONE,
		BS_DONE2
	} branch_state_t;

	// true for every state from checkpoint restore up to the last done state
	// while this holds, every registered stage in the front end is stomped
	function automatic logic in_recovery(input branch_state_t state);
		in_recovery = (state >= BS_CHKPT_RESTORE) && (state <= BS_DONE2);
	endfunction

endpackage

// File: verilog/pipe_pkg.sv
// stage ids are ordered fetch first, queue last, and index the stage arrays in that order
package pipe_pkg;

	// single bit constants for valid and stomp flags
	localparam logic TRUE = 1'b1;
	localparam logic FALSE = 1'b0;

	// the seven front end stages from fetch to queue write
	// segment one runs from mux to dec, segment two holds ren and que
	typedef enum logic [2:0] {
		FET,
		MUX,
		VEC,
		PCK,
		DEC,
		REN,
		QUE
	} stage_id_t;

	// fetch itself has no stage register, the first registered stage is MUX
	// the array code steps through the ids with plus and minus one

endpackage

// File: verilog/branch_recovery.sv
// a branch miss that arrives while recovery is already running is dropped, not queued
`include "frontend_defs.svh"

module branch_recovery import branch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic branchmiss,
	input logic [`ADDR_W-1:0] miss_pc,
	output branch_state_t branch_state,
	output logic redirect,
	output logic [`ADDR_W-1:0] redirect_pc
);

	// ==========================================================================
	// recovery FSM
	// ==========================================================================

	branch_state_t branch_state_next;
	logic [2:0] recovery_step;
	logic [`ADDR_W-1:0] target_pc;

	// the enum numbering makes the state value equal to its step in the window
	assign recovery_step = branch_state;

	always_comb begin
		branch_state_next = branch_state;
		case (branch_state)
			BS_IDLE: begin
				// only an idle machine accepts a new miss
				if (branchmiss)
					branch_state_next = BS_CHKPT_RESTORE;
			end
			default: begin
				// one recovery state per cycle, back to idle after the last step
				if (recovery_step == `RECOVERY_STEPS)
					branch_state_next = BS_IDLE;
				else
					branch_state_next = branch_state_t'(branch_state + 3'd1);
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			branch_state <= BS_IDLE;
		else
			branch_state <= branch_state_next;
	end

	// ==========================================================================
	// redirect target
	// ==========================================================================

	// capture the missed target when the miss is accepted
	// the reset value gives fetch a defined restart address
	always_ff @(posedge clk) begin
		if (rst)
			target_pc <= `RESET_PC;
		else if (branchmiss && branch_state == BS_IDLE)
			target_pc <= miss_pc;
	end

	// fetch restarts in the last recovery cycle, once the checkpoint is back
	assign redirect = (branch_state == BS_DONE2);
	assign redirect_pc = target_pc;

endmodule

// File: verilog/pipeline_stomp.sv
// registered stomps only update on an advance, so a miss during a full stall needs the window
module pipeline_stomp import branch_pkg::*, pipe_pkg::*; (
	input logic clk,
	input logic rst,
	input logic ihit,
	input logic advance_pipeline,
	input logic advance_pipeline_seg2,
	input logic micro_code_active,
	input logic branchmiss,
	input branch_state_t branch_state,
	output logic stomp_fet,
	output logic stomp_mux,
	output logic stomp_vec,
	output logic stomp_pck,
	output logic stomp_dec,
	output logic stomp_ren,
	output logic stomp_que,
	output logic stomp_quem
);

	logic flush_all;
	logic next_stomp_mux;
	logic next_stomp_vec;
	logic next_stomp_pck;
	logic next_stomp_dec;
	logic next_stomp_ren;
	logic next_stomp_quem;

	// ==========================================================================
	// stomp sources
	// ==========================================================================

	// a branch miss or a running recovery kills every registered stage at once
	assign flush_all = branchmiss || in_recovery(branch_state);

	// without cache data the fetch group is garbage
	assign stomp_fet = !ihit;

	// micro-code supplies its own group at mux, so a cache miss is harmless then
	assign next_stomp_mux = (stomp_fet && !micro_code_active) || flush_all;

	// the rest ripple one stage per advance, like the groups they describe
	assign next_stomp_vec = stomp_mux || flush_all;
	assign next_stomp_pck = stomp_vec || flush_all;
	assign next_stomp_dec = stomp_pck || flush_all;
	assign next_stomp_ren = stomp_dec || flush_all;

	// a group leaving ren has been renamed already
	// it cannot simply vanish, it is marked to become a copy target instead
	assign next_stomp_quem = flush_all;

	// ==========================================================================
	// segment one stomps
	// ==========================================================================

	// all stomps start high so nothing left over from reset gets written
	always_ff @(posedge clk) begin
		if (rst) begin
			stomp_mux <= TRUE;
			stomp_vec <= TRUE;
			stomp_pck <= TRUE;
			stomp_dec <= TRUE;
		end else if (advance_pipeline) begin
			stomp_mux <= next_stomp_mux;
			stomp_vec <= next_stomp_vec;
			stomp_pck <= next_stomp_pck;
			stomp_dec <= next_stomp_dec;
		end
	end

	// ==========================================================================
	// segment two stomps
	// ==========================================================================

	// que only inherits the ren stomp, since a group that was live at rename
	// still has to reach the queue
	always_ff @(posedge clk) begin
		if (rst) begin
			stomp_ren <= TRUE;
			stomp_que <= TRUE;
			stomp_quem <= TRUE;
		end else if (advance_pipeline_seg2) begin
			stomp_ren <= next_stomp_ren;
			stomp_que <= stomp_ren;
			stomp_quem <= next_stomp_quem;
		end
	end

endmodule

// File: verilog/frontend_pipe.sv
// fetch presents no group until the cache has hit once after reset, then one per advance
`include "frontend_defs.svh"

module frontend_pipe import pipe_pkg::*; (
	input logic clk,
	input logic rst,
	input logic ihit,
	input logic [`ADDR_W-1:0] fetch_pc,
	input logic que_full,
	input logic ren_stall,
	input logic stomp_fet,
	input logic stomp_mux,
	input logic stomp_vec,
	input logic stomp_pck,
	input logic stomp_dec,
	input logic stomp_ren,
	input logic stomp_que,
	input logic stomp_quem,
	output logic advance_pipeline,
	output logic advance_pipeline_seg2,
	output logic que_wr,
	output logic [`ADDR_W-1:0] que_pc,
	output logic que_copy_target
);

	logic stage_valid [MUX:QUE];
	logic [`ADDR_W-1:0] stage_pc [MUX:QUE];
	logic stage_stomp [FET:QUE];
	logic fetch_seen;
	logic fetch_valid;

	// ==========================================================================
	// segment advance
	// ==========================================================================

	// a full queue freezes everything, rename only holds back segment one
	assign advance_pipeline_seg2 = !que_full;
	assign advance_pipeline = !que_full && !ren_stall;

	// ==========================================================================
	// stage bookkeeping
	// ==========================================================================

	// gather the stomps by stage id so the shift below can walk them
	always_comb begin
		stage_stomp[FET] = stomp_fet;
		stage_stomp[MUX] = stomp_mux;
		stage_stomp[VEC] = stomp_vec;
		stage_stomp[PCK] = stomp_pck;
		stage_stomp[DEC] = stomp_dec;
		stage_stomp[REN] = stomp_ren;
		stage_stomp[QUE] = stomp_que;
	end

	// after the first hit fetch always offers a group
	// a later cache miss is handled by the stomps, which let micro-code through
	assign fetch_valid = fetch_seen || !stage_stomp[FET];

	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_seen <= FALSE;
			for (int s = MUX; s <= QUE; s++)
				stage_valid[s] <= FALSE;
		end else begin
			if (ihit)
				fetch_seen <= TRUE;
			// segment one shifts as a block
			if (advance_pipeline) begin
				stage_valid[MUX] <= fetch_valid;
				for (int s = VEC; s <= DEC; s++)
					stage_valid[s] <= stage_valid[s - 1] && !stage_stomp[s - 1];
			end
			// ren takes a bubble when rename drains but decode is held
			if (advance_pipeline_seg2) begin
				stage_valid[QUE] <= stage_valid[REN] && !stage_stomp[REN];
				if (advance_pipeline)
					stage_valid[REN] <= stage_valid[DEC] && !stage_stomp[DEC];
				else
					stage_valid[REN] <= FALSE;
			end
		end
	end

	// addresses follow the same advances, the valid bits say which ones count
	always_ff @(posedge clk) begin
		if (advance_pipeline) begin
			stage_pc[MUX] <= fetch_pc;
			for (int s = VEC; s <= REN; s++)
				stage_pc[s] <= stage_pc[s - 1];
		end
		if (advance_pipeline_seg2)
			stage_pc[QUE] <= stage_pc[REN];
	end

	// ==========================================================================
	// queue write
	// ==========================================================================

	// the entry goes out in the same cycle that que hands it on
	// so a held queue neither drops nor repeats it
	assign que_wr = stage_valid[QUE] && !stage_stomp[QUE] && advance_pipeline_seg2;
	assign que_pc = stage_pc[QUE];

	// a group caught by a miss after rename is queued as a copy target
	assign que_copy_target = stomp_quem;

endmodule

// File: verilog/frontend_top.sv
// all logic runs on one clock, back-pressure and the miss pulse must be synchronous to it
`include "frontend_defs.svh"

module frontend_top import branch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic ihit,
	input logic micro_code_active,
	input logic branchmiss,
	input logic que_full,
	input logic ren_stall,
	input logic [`ADDR_W-1:0] fetch_pc,
	input logic [`ADDR_W-1:0] miss_pc,
	output logic que_wr,
	output logic que_copy_target,
	output logic redirect,
	output logic [`ADDR_W-1:0] que_pc,
	output logic [`ADDR_W-1:0] redirect_pc,
	output branch_state_t branch_state
);

	// segment strobes from the pipe and the stomp waterfall back into it
	logic advance_pipeline;
	logic advance_pipeline_seg2;
	logic stomp_fet;
	logic stomp_mux;
	logic stomp_vec;
	logic stomp_pck;
	logic stomp_dec;
	logic stomp_ren;
	logic stomp_que;
	logic stomp_quem;

	// the recovery FSM runs regardless of back-pressure
	branch_recovery u_branch_recovery (
		.clk(clk),
		.rst(rst),
		.branchmiss(branchmiss),
		.miss_pc(miss_pc),
		.branch_state(branch_state),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

	pipeline_stomp u_pipeline_stomp (
		.clk(clk),
		.rst(rst),
		.ihit(ihit),
		.advance_pipeline(advance_pipeline),
		.advance_pipeline_seg2(advance_pipeline_seg2),
		.micro_code_active(micro_code_active),
		.branchmiss(branchmiss),
		.branch_state(branch_state),
		.stomp_fet(stomp_fet),
		.stomp_mux(stomp_mux),
		.stomp_vec(stomp_vec),
		.stomp_pck(stomp_pck),
		.stomp_dec(stomp_dec),
		.stomp_ren(stomp_ren),
		.stomp_que(stomp_que),
		.stomp_quem(stomp_quem)
	);

	frontend_pipe u_frontend_pipe (
		.clk(clk),
		.rst(rst),
		.ihit(ihit),
		.fetch_pc(fetch_pc),
		.que_full(que_full),
		.ren_stall(ren_stall),
		.stomp_fet(stomp_fet),
		.stomp_mux(stomp_mux),
		.stomp_vec(stomp_vec),
		.stomp_pck(stomp_pck),
		.stomp_dec(stomp_dec),
		.stomp_ren(stomp_ren),
		.stomp_que(stomp_que),
		.stomp_quem(stomp_quem),
		.advance_pipeline(advance_pipeline),
		.advance_pipeline_seg2(advance_pipeline_seg2),
		.que_wr(que_wr),
		.que_pc(que_pc),
		.que_copy_target(que_copy_target)
	);

endmodule

// File: test/frontend_tb.sv
// outputs are checked at each falling edge against a cycle model fed by inputs set after rising edges
`include "frontend_defs.svh"

module frontend_tb import branch_pkg::*, pipe_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic clk = 1'b0;
	logic rst;
	logic ihit;
	logic micro_code_active;
	logic branchmiss;
	logic que_full;
	logic ren_stall;
	logic [`ADDR_W-1:0] fetch_pc;
	logic [`ADDR_W-1:0] miss_pc;
	logic que_wr;
	logic que_copy_target;
	logic redirect;
	logic [`ADDR_W-1:0] que_pc;
	logic [`ADDR_W-1:0] redirect_pc;
	branch_state_t branch_state;

	// the reference model keeps one slot per registered stage and alive means it will be written
	logic m_alive [MUX:QUE];
	logic [`ADDR_W-1:0] m_pc [MUX:QUE];
	logic m_copy;
	logic m_seen;
	branch_state_t m_bs;
	logic [`ADDR_W-1:0] m_target;
	// unstomped fetches wait here in order until order_check compares them with the writes
	logic [`ADDR_W-1:0] fetch_q [$];
	logic order_check;
	integer seed;
	int errors;
	int tests;
	int writes;
	int copies;
	int redirects;
	int errors_at_start;

	always #50 clk = ~clk;

	frontend_top u_frontend_top (
		.clk(clk),
		.rst(rst),
		.ihit(ihit),
		.micro_code_active(micro_code_active),
		.branchmiss(branchmiss),
		.que_full(que_full),
		.ren_stall(ren_stall),
		.fetch_pc(fetch_pc),
		.miss_pc(miss_pc),
		.que_wr(que_wr),
		.que_copy_target(que_copy_target),
		.redirect(redirect),
		.que_pc(que_pc),
		.redirect_pc(redirect_pc),
		.branch_state(branch_state)
	);

	// ==========================================================================
	// checks
	// ==========================================================================

	// a full queue must never see a write
	assert property (@(posedge clk) disable iff (rst) que_full |-> !que_wr)
		else begin
			$display("que_wr was high in a cycle where que_full was high");
			errors++;
		end

	task automatic report_value(input string name, input logic [`ADDR_W-1:0] expected,
		input logic [`ADDR_W-1:0] actual);
		$display("FAILED %s expected %h actual %h", name, expected, actual);
		errors++;
	endtask

	task automatic check_outputs();
		logic exp_wr;
		exp_wr = m_alive[QUE] && !que_full;
		assert (que_wr === exp_wr) else report_value("que_wr", exp_wr, que_wr);
		if (exp_wr) begin
			assert (que_pc === m_pc[QUE]) else report_value("que_pc", m_pc[QUE], que_pc);
			assert (que_copy_target === m_copy)
				else report_value("que_copy_target", m_copy, que_copy_target);
		end
		assert (branch_state === m_bs) else report_value("branch_state", m_bs, branch_state);
		assert (redirect === (m_bs == BS_DONE2))
			else report_value("redirect", m_bs == BS_DONE2, redirect);
		if (m_bs == BS_DONE2) begin
			assert (redirect_pc === m_target)
				else report_value("redirect_pc", m_target, redirect_pc);
		end
	endtask

	task automatic count_events();
		logic [`ADDR_W-1:0] expected;
		if (redirect)
			redirects++;
		if (que_wr) begin
			writes++;
			if (que_copy_target)
				copies++;
			if (order_check) begin
				assert (fetch_q.size() != 0)
					else begin
						$display("que_wr wrote an entry that was never fetched");
						errors++;
					end
				if (fetch_q.size() != 0) begin
					expected = fetch_q.pop_front();
					assert (que_pc === expected)
						else report_value("que_pc order", expected, que_pc);
				end
			end
		end
	endtask

	// ==========================================================================
	// reference model
	// ==========================================================================

	task automatic reset_model();
		for (int s = MUX; s <= QUE; s++)
			m_alive[s] = FALSE;
		m_copy = FALSE;
		m_seen = FALSE;
		m_bs = BS_IDLE;
		m_target = `RESET_PC;
	endtask

	// moves the model across the coming rising edge with the inputs of this cycle
	task automatic step_model();
		logic flush;
		logic fetch_ok;
		flush = branchmiss || (m_bs != BS_IDLE);
		// micro-code only covers a cache miss once fetch has ever hit
		fetch_ok = ihit || (m_seen && micro_code_active);
		if (!que_full) begin
			// a flush as a group enters que only marks it as a copy target
			m_alive[QUE] = m_alive[REN];
			m_pc[QUE] = m_pc[REN];
			m_copy = flush;
			m_alive[REN] = FALSE;
			if (!ren_stall) begin
				m_alive[REN] = m_alive[DEC] && !flush;
				m_pc[REN] = m_pc[DEC];
				for (int s = DEC; s > MUX; s--) begin
					m_alive[s] = m_alive[s - 1] && !flush;
					m_pc[s] = m_pc[s - 1];
				end
				m_alive[MUX] = fetch_ok && !flush;
				m_pc[MUX] = fetch_pc;
				if (order_check && m_alive[MUX])
					fetch_q.push_back(fetch_pc);
			end
		end
		if (ihit)
			m_seen = TRUE;
		// recovery steps once per cycle and a miss inside it is ignored
		if (m_bs == BS_IDLE) begin
			if (branchmiss) begin
				m_bs = BS_CHKPT_RESTORE;
				m_target = miss_pc;
			end
		end else if (m_bs == BS_DONE2)
			m_bs = BS_IDLE;
		else
			m_bs = branch_state_t'(m_bs + 3'd1);
	endtask

	function automatic logic pipe_busy();
		pipe_busy = (m_bs != BS_IDLE);
		for (int s = MUX; s <= QUE; s++)
			if (m_alive[s])
				pipe_busy = TRUE;
	endfunction

	always @(negedge clk) begin
		if (rst)
			reset_model();
		check_outputs();
		count_events();
		if (!rst)
			step_model();
	end

	// ==========================================================================
	// stimulus helpers
	// ==========================================================================

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic idle_inputs();
		ihit = FALSE;
		micro_code_active = FALSE;
		branchmiss = FALSE;
		que_full = FALSE;
		ren_stall = FALSE;
	endtask

	task automatic start_test();
		writes = 0;
		copies = 0;
		redirects = 0;
		errors_at_start = errors;
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %0d %s: %0d writes, %0d new errors", tests, name, writes,
			errors - errors_at_start);
	endtask

	// runs until every modeled group has left the pipe and recovery is idle
	task automatic drain();
		int waited;
		stage_id_t stuck;
		waited = 0;
		stuck = FET;
		next_cycle();
		idle_inputs();
		while (pipe_busy()) begin
			if (waited == 40) begin
				for (int s = MUX; s <= QUE; s++)
					if (m_alive[s])
						stuck = stage_id_t'(s);
				$display("pipe did not drain, last live stage %s and recovery in %s",
					stuck.name(), m_bs.name());
				$display("Simulation FAILED");
				$finish;
			end
			next_cycle();
			waited++;
		end
	endtask

	task automatic wait_for_redirect();
		int waited;
		waited = 0;
		while (!redirect) begin
			if (waited == 10) begin
				$display("redirect never pulsed after the branch miss");
				$display("Simulation FAILED");
				$finish;
			end
			next_cycle();
			waited++;
		end
	endtask

	// ==========================================================================
	// tests
	// ==========================================================================

	initial begin
		logic [31:0] r;
		seed = 32'h0fbd1a7a;
		errors = 0;
		tests = 0;
		rst = 1'b1;
		idle_inputs();
		fetch_pc = '0;
		miss_pc = '0;
		order_check = FALSE;
		repeat (8) @(posedge clk);
		#10;
		rst = 1'b0;

		// reset leaves everything quiet for six cycles
		start_test();
		for (int i = 0; i < 6; i++) begin
			next_cycle();
			assert (!que_wr && !redirect && branch_state == BS_IDLE)
				else begin
					$display("outputs were active just after reset");
					errors++;
				end
		end
		finish_test("reset");

		start_test();
		for (int i = 0; i < 20; i++) begin
			next_cycle();
			ihit = TRUE;
			fetch_pc = 32'h0000_1000 + i * 4;
		end
		drain();
		assert (writes == 20) else report_value("que_wr count", 20, writes);
		finish_test("flow");

		// a miss without micro-code is dropped, with micro-code it still goes out
		start_test();
		for (int i = 0; i < 4; i++) begin
			next_cycle();
			fetch_pc = 32'h0000_3000 + i * 4;
		end
		drain();
		assert (writes == 0) else report_value("que_wr count", 0, writes);
		for (int i = 0; i < 4; i++) begin
			next_cycle();
			micro_code_active = TRUE;
			fetch_pc = 32'h0000_4000 + i * 4;
		end
		drain();
		assert (writes == 4) else report_value("que_wr count", 4, writes);
		finish_test("cache_miss");

		// a second miss lands inside the window and has to be ignored
		start_test();
		for (int i = 0; i < 10; i++) begin
			next_cycle();
			ihit = TRUE;
			fetch_pc = 32'h0000_2000 + i * 4;
		end
		next_cycle();
		branchmiss = TRUE;
		miss_pc = 32'h0000_8100;
		next_cycle();
		branchmiss = FALSE;
		next_cycle();
		branchmiss = TRUE;
		miss_pc = 32'h0000_dea0;
		next_cycle();
		branchmiss = FALSE;
		wait_for_redirect();
		for (int i = 0; i < 4; i++) begin
			next_cycle();
			fetch_pc = 32'h0000_8100 + i * 4;
		end
		drain();
		assert (redirects == 1) else report_value("redirect count", 1, redirects);
		assert (copies == 1) else report_value("que_copy_target count", 1, copies);
		finish_test("branch_miss");

		start_test();
		order_check = TRUE;
		for (int i = 0; i < 200; i++) begin
			next_cycle();
			r = $random(seed);
			ihit = r[0] | r[1];
			que_full = r[2] & r[3];
			ren_stall = r[4] & r[5];
			fetch_pc = $random(seed);
		end
		drain();
		assert (fetch_q.size() == 0) else report_value("unwritten fetches", 0, fetch_q.size());
		order_check = FALSE;
		finish_test("back_pressure");

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
verilog/branch_pkg.sv
verilog/pipe_pkg.sv
verilog/branch_recovery.sv
verilog/pipeline_stomp.sv
verilog/frontend_pipe.sv
verilog/frontend_top.sv
test/frontend_tb.sv
